// ==== run.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module dmc_tb -o sim_dmc

out=$(./obj_dir/sim_dmc 2>&1) || true
echo "$out"

if grep -qx "No errors" <<< "$out"; then
	exit 0
else
	exit 1
fi

// ==== tb/dmc_mem_model.sv ====
module dmc_mem_model (
	input logic clk,
	input logic n_reset,
	input dmc_pkg::mem_req_t mem_req,
	output logic mem_rdy,
	output logic [7:0] mem_data
);

timeunit 1ns;
timeprecision 100ps;

int delay;
logic busy;

// Sample contents depend on every address bit
function automatic logic [7:0] byte_at(input logic [15:0] a);
	return (a[7:0] * 8'd29) ^ a[15:8] ^ {a[3:0], a[7:4]};
endfunction

initial begin
	mem_rdy = 1'b0;
	mem_data = 8'h0;
	busy = 1'b0;
	delay = 0;
	void'($urandom(32'h50aad3a0));
	forever begin
		@(negedge clk);
		if (!n_reset) begin
			mem_rdy = 1'b0;
			busy = 1'b0;
		end else if (mem_rdy) begin
			mem_rdy = 1'b0;
		end else if (busy) begin
			delay--;
			if (delay == 0) begin
				mem_rdy = 1'b1; // One-cycle answer carrying the byte
				mem_data = byte_at(mem_req.addr);
				busy = 1'b0;
			end
		end else if (mem_req.req) begin
			busy = 1'b1;
			delay = $urandom_range(6, 1);
		end
	end
end

endmodule

// ==== tb/dmc_tb.sv ====
`include "dmc_defs.svh"

module dmc_tb;

timeunit 1ns;
timeprecision 100ps;

localparam int N = `DMC_NUM_CHANNELS;
localparam int SLOTS = 121 + 16; // Byte slots over all tests plus silent ones
localparam int LIMIT = SLOTS * 8 * 54 + 20000;

logic clk, n_reset, sys_we, mem_rdy;
logic [15:0] sys_addr;
logic [7:0] sys_wdata, mem_data;
dmc_pkg::mem_req_t mem_req;
logic [`DMC_MIX_W-1:0] mix_out;
logic [N-1:0] act, irq;
logic [15:0] req_addr;
logic [15:0] fetched [$];
int cycles = 0;
int waits [N];
int exp_lvl [N];
int per_ch [N];

tb_clock clk0 (.clk(clk), .n_reset(n_reset));
dmc_mem_model mem0 (.clk(clk), .n_reset(n_reset), .mem_req(mem_req), .mem_rdy(mem_rdy),
	.mem_data(mem_data));
dmc_top dut (.clk(clk), .n_reset(n_reset), .sys_we(sys_we), .sys_addr(sys_addr),
	.sys_wdata(sys_wdata), .mem_rdy(mem_rdy), .mem_data(mem_data), .mem_req(mem_req),
	.mix_out(mix_out), .act(act), .irq(irq));

assign req_addr = mem_req.addr;

task automatic stop_on_error(input string msg);
	$display("%s", msg);
	$display("Errors found");
	$fatal(1, "simulation stopped");
endtask

task automatic check_eq(input string name, input int exp, input int got);
	assert (exp == got)
	else stop_on_error($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, got));
endtask

task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
	@(negedge clk);
	sys_we = 1'b1;
	sys_addr = addr;
	sys_wdata = data;
	@(negedge clk);
	sys_we = 1'b0;
endtask

function automatic logic [15:0] reg_addr(input int ch, input int idx);
	return `DMC_BASE_ADDR + 16'(4 * ch + idx);
endfunction

function automatic logic [15:0] sample_base(input int areg);
	return 16'hC000 + 16'(64 * areg);
endfunction

// Clamped delta steps, least significant bit first
function automatic int apply_byte(input int lvl, input logic [7:0] b);
	for (int i = 0; i < 8; i++) begin
		if (b[i]) begin
			if (lvl <= 125)
				lvl += 2;
		end else if (lvl >= 2) begin
			lvl -= 2;
		end
	end
	return lvl;
endfunction

task automatic set_level(input int ch, input int lvl);
	write_reg(reg_addr(ch, 1), 8'(lvl));
	exp_lvl[ch] = lvl;
endtask

task automatic setup_channel(input int ch, input logic [7:0] ctrl, input int areg);
	write_reg(reg_addr(ch, 0), ctrl);
	write_reg(reg_addr(ch, 2), 8'(areg));
	write_reg(reg_addr(ch, 3), 8'h01); // 17 bytes per sample
endtask

task automatic play_model(input int ch, input int areg);
	for (int i = 0; i < 17; i++)
		exp_lvl[ch] = apply_byte(exp_lvl[ch], mem0.byte_at(sample_base(areg) + 16'(i)));
endtask

task automatic check_mix(input string name);
	int sum;
	sum = 0;
	repeat (2) @(posedge clk);
	@(negedge clk);
	for (int c = 0; c < N; c++)
		sum += exp_lvl[c];
	check_eq(name, sum, int'(mix_out));
endtask

task automatic wait_idle(input logic [N-1:0] mask);
	repeat (4) @(negedge clk);
	while ((act & mask) != '0)
		@(negedge clk);
endtask

always @(posedge clk) begin
	cycles++;
	if (cycles > LIMIT)
		stop_on_error($sformatf("Timeout: run did not finish within %0d cycles", LIMIT));
	if (n_reset && mem_req.req && mem_rdy) begin
		fetched.push_back(mem_req.addr);
		for (int c = 0; c < N; c++) begin
			if (dut.fetch_rsp[c].rdy || !dut.fetch_req[c].req) begin
				waits[c] = 0;
			end else begin
				waits[c]++;
				assert (waits[c] <= N)
				else stop_on_error($sformatf("Channel %0d waited too many fetches", c));
			end
		end
	end
end

assert property (@(posedge clk) disable iff (!n_reset)
	(mem_req.req && !mem_rdy) |=> (mem_req.req && $stable(req_addr)))
else stop_on_error("mem_req dropped or changed its address before mem_rdy");

initial begin
	sys_we = 1'b0;
	sys_addr = 16'h0;
	sys_wdata = 8'h0;
	for (int c = 0; c < N; c++) begin
		exp_lvl[c] = 0;
		waits[c] = 0;
	end
	@(posedge n_reset);
	@(negedge clk);
	check_eq("reset_mix", 0, int'(mix_out));
	check_eq("reset_act_irq_req", 0, int'({act, irq, mem_req.req}));

	set_level(0, 17);
	set_level(2, 60);
	set_level(3, 99); // Channel 1 level address is shadowed by the control register
	@(posedge clk);
	@(negedge clk);
	check_eq("level_mix_early", 17 + 60, int'(mix_out));
	@(posedge clk);
	@(negedge clk);
	check_eq("level_mix", 17 + 60 + 99, int'(mix_out));

	fetched.delete();
	setup_channel(0, 8'h0F, 3);
	write_reg(`DMC_CTRL_ADDR, 8'h01);
	wait_idle(4'b0001);
	check_eq("fetch_count", 17, fetched.size());
	for (int i = 0; i < fetched.size(); i++)
		check_eq("fetch_addr", int'(sample_base(3)) + i, int'(fetched[i]));
	play_model(0, 3);
	check_mix("fetch_play_mix");
	repeat (100) @(negedge clk);
	check_eq("fetch_quiet", 17, fetched.size());

	set_level(2, 1);
	setup_channel(2, 8'h0F, 5);
	write_reg(`DMC_CTRL_ADDR, 8'h04);
	wait_idle(4'b0100);
	play_model(2, 5);
	check_mix("delta_low");
	set_level(2, 126);
	write_reg(reg_addr(2, 2), 8'd9);
	write_reg(`DMC_CTRL_ADDR, 8'h04);
	wait_idle(4'b0100);
	play_model(2, 9);
	check_mix("delta_high");

	fetched.delete();
	setup_channel(0, 8'hCF, 7);
	write_reg(`DMC_CTRL_ADDR, 8'h01);
	while (fetched.size() < 36) begin
		@(negedge clk);
		check_eq("loop_irq", 0, int'(irq));
	end
	for (int i = 0; i < 36; i++)
		check_eq("loop_addr", int'(sample_base(7)) + i % 17, int'(fetched[i]));
	write_reg(`DMC_CTRL_ADDR, 8'h00);
	set_level(0, 40);

	fetched.delete();
	setup_channel(3, 8'h8F, 11);
	write_reg(`DMC_CTRL_ADDR, 8'h08);
	while (!irq[3])
		@(negedge clk);
	check_eq("irq_after_last_fetch", 17, fetched.size());
	wait_idle(4'b1000);
	play_model(3, 11);
	check_mix("irq_play_mix");
	check_eq("irq_held", 1, int'(irq[3]));
	write_reg(`DMC_CTRL_ADDR, 8'h00);
	@(posedge clk);
	@(negedge clk);
	check_eq("irq_cleared", 0, int'(irq));

	fetched.delete();
	for (int c = 0; c < N; c++)
		setup_channel(c, 8'h0F, 2 * c);
	write_reg(`DMC_CTRL_ADDR, 8'(2 ** N - 1));
	wait_idle('1);
	for (int c = 0; c < N; c++)
		per_ch[c] = 0;
	foreach (fetched[i]) begin
		assert (fetched[i] >= 16'hC000 && int'(fetched[i] - 16'hC000) % 128 < 17
			&& int'(fetched[i] - 16'hC000) / 128 < N)
		else stop_on_error($sformatf("Fetch address %h is outside every sample", fetched[i]));
		per_ch[int'(fetched[i] - 16'hC000) / 128]++;
	end
	for (int c = 0; c < N; c++) begin
		check_eq($sformatf("arb_count_ch%0d", c), 17, per_ch[c]);
		play_model(c, 2 * c);
	end
	check_mix("arb_mix");

	$display("No errors");
	$finish;
end

endmodule

// ==== tb/tb_clock.sv ====
module tb_clock (
	output logic clk,
	output logic n_reset
);

timeunit 1ns;
timeprecision 100ps;

initial begin
	clk = 1'b0;
	forever #4 clk = ~clk;
end

initial begin
	n_reset = 1'b0;
	repeat (5) @(posedge clk);
	@(negedge clk);
	n_reset = 1'b1;
end

endmodule

// ==== verilog/dmc_channel.sv ====
`include "dmc_defs.svh"

module dmc_channel (
	input logic clk,
	input logic n_reset,
	input dmc_pkg::reg_wr_t reg_wr,
	input logic en,
	input logic start,
	input logic irq_clr,
	output dmc_pkg::fetch_req_t fetch_req,
	input dmc_pkg::fetch_rsp_t fetch_rsp,
	output logic [6:0] level,
	output logic act,
	output logic irq
);

dmc_pkg::dmc_ctrl_t ctrl_reg;
logic [7:0] addr_reg;
logic [7:0] len_reg;

logic [15:0] cur_addr;
logic [11:0] bytes_left;
logic got_byte;
logic last_byte;

logic buf_full;
logic [7:0] buf_data;
logic [7:0] shift;
logic shift_valid;

logic [`DMC_TIMER_W-1:0] period;
logic [`DMC_TIMER_W-1:0] timer;
logic [2:0] bit_cnt;
logic tick;
logic slot_start;

dmc_rate_rom rom0 (.rate(ctrl_reg.rate), .period(period));

always_ff @(posedge clk, negedge n_reset) begin
	if (~n_reset) begin
		ctrl_reg <= '0;
		addr_reg <= 8'h0;
		len_reg <= 8'h0;
	end else if (reg_wr.valid) begin
		case (reg_wr.idx)
			`DMC_REG_CTRL: ctrl_reg <= reg_wr.data.ctrl;
			`DMC_REG_ADDR: addr_reg <= reg_wr.data.raw;
			`DMC_REG_LEN: len_reg <= reg_wr.data.raw;
			default: ;
		endcase
	end
end

assign fetch_req.req = en && !buf_full && bytes_left != 12'h0;
assign fetch_req.addr = cur_addr;
assign got_byte = fetch_rsp.rdy && fetch_req.req;
assign last_byte = got_byte && bytes_left == 12'h1;

always_ff @(posedge clk, negedge n_reset) begin
	if (~n_reset) begin
		cur_addr <= 16'h0;
		bytes_left <= 12'h0;
	end else if (!en) begin
		cur_addr <= 16'h0;
		bytes_left <= 12'h0;
	end else if (start || (last_byte && ctrl_reg.loop)) begin
		cur_addr <= `DMC_SAMPLE_BASE + {2'b00, addr_reg, 6'h00};
		bytes_left <= {len_reg, 4'h1};
	end else if (got_byte) begin
		cur_addr <= cur_addr + 16'h1;
		bytes_left <= bytes_left - 12'h1;
	end
end

always_ff @(posedge clk, negedge n_reset) begin
	if (~n_reset)
		irq <= 1'b0;
	else if (irq_clr || !ctrl_reg.irq_en)
		irq <= 1'b0;
	else if (last_byte && !ctrl_reg.loop)
		irq <= 1'b1;
end

assign tick = timer == '0;
assign slot_start = tick && bit_cnt == 3'd7;

always_ff @(posedge clk, negedge n_reset) begin
	if (~n_reset) begin
		timer <= '0;
		bit_cnt <= 3'd7; // First expiry opens a byte slot
	end else if (tick) begin
		timer <= period - 1'b1;
		bit_cnt <= bit_cnt + 3'd1;
	end else begin
		timer <= timer - 1'b1;
	end
end

always_ff @(posedge clk, negedge n_reset) begin
	if (~n_reset) begin
		buf_full <= 1'b0;
		shift_valid <= 1'b0;
	end else if (!en) begin
		buf_full <= 1'b0;
		shift_valid <= 1'b0;
	end else begin
		if (slot_start)
			shift_valid <= buf_full; // Slot plays silent without a buffered byte
		if (got_byte)
			buf_full <= 1'b1; // A byte landing at a slot start waits for the next slot
		else if (slot_start)
			buf_full <= 1'b0;
	end
end

always_ff @(posedge clk) begin
	if (got_byte)
		buf_data <= fetch_rsp.data;
	if (slot_start)
		shift <= buf_data;
	else if (tick)
		shift <= {1'b0, shift[7:1]};
end

always_ff @(posedge clk, negedge n_reset) begin
	if (~n_reset) begin
		level <= 7'h0;
	end else if (reg_wr.valid && reg_wr.idx == `DMC_REG_LEVEL) begin
		level <= reg_wr.data.lvl.level;
	end else if (tick && shift_valid) begin
		if (shift[0]) begin
			if (level <= 7'd125)
				level <= level + 7'd2;
		end else if (level >= 7'd2) begin
			level <= level - 7'd2;
		end
	end
end

// Busy until the last fetched byte has been shifted out
assign act = bytes_left != 12'h0 || buf_full || shift_valid;

endmodule

// ==== verilog/dmc_defs.svh ====
`ifndef DMC_DEFS_SVH
`define DMC_DEFS_SVH

`define DMC_NUM_CHANNELS 4

// Channel c owns the four addresses from DMC_BASE_ADDR + 4c
`define DMC_BASE_ADDR 16'h4010
`define DMC_CTRL_ADDR 16'h4015

`define DMC_REG_CTRL 2'd0
`define DMC_REG_LEVEL 2'd1
`define DMC_REG_ADDR 2'd2
`define DMC_REG_LEN 2'd3

`define DMC_SAMPLE_BASE 16'hC000

`define DMC_TIMER_W 9
`define DMC_MIX_W (7 + $clog2(`DMC_NUM_CHANNELS))

`endif

// ==== verilog/dmc_fetch_arbiter.sv ====
`include "dmc_defs.svh"

module dmc_fetch_arbiter (
	input logic clk,
	input logic n_reset,
	input dmc_pkg::fetch_req_t fetch_req [`DMC_NUM_CHANNELS],
	output dmc_pkg::fetch_rsp_t fetch_rsp [`DMC_NUM_CHANNELS],
	output dmc_pkg::mem_req_t mem_req,
	input logic mem_rdy,
	input logic [7:0] mem_data
);

localparam int N = `DMC_NUM_CHANNELS;
localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

logic [IDX_W-1:0] gnt_idx;
logic [IDX_W-1:0] last_idx;
logic [IDX_W-1:0] pick_idx;
logic pick_found;

// Search starts at the channel after the one served last
always_comb begin
	int c;
	pick_found = 1'b0;
	pick_idx = last_idx;
	for (int i = 1; i <= N; i++) begin
		c = (int'(last_idx) + i) % N;
		if (!pick_found && fetch_req[c].req) begin
			pick_found = 1'b1;
			pick_idx = IDX_W'(c);
		end
	end
end

always_ff @(posedge clk, negedge n_reset) begin
	if (~n_reset) begin
		mem_req <= '0;
		gnt_idx <= '0;
		last_idx <= IDX_W'(N - 1);
	end else if (mem_req.req) begin
		if (mem_rdy) begin
			mem_req.req <= 1'b0;
			last_idx <= gnt_idx;
		end
	end else if (pick_found) begin
		mem_req.req <= 1'b1;
		mem_req.addr <= fetch_req[pick_idx].addr; // Held here until mem_rdy
		gnt_idx <= pick_idx;
	end
end

always_comb begin
	for (int c = 0; c < N; c++) begin
		fetch_rsp[c].rdy = mem_req.req && mem_rdy && gnt_idx == IDX_W'(c);
		fetch_rsp[c].data = mem_data;
	end
end

endmodule

// ==== verilog/dmc_mixer.sv ====
`include "dmc_defs.svh"

module dmc_mixer (
	input logic clk,
	input logic n_reset,
	input logic [6:0] level [`DMC_NUM_CHANNELS],
	output logic [`DMC_MIX_W-1:0] mix_out
);

localparam int N = `DMC_NUM_CHANNELS;

logic [`DMC_MIX_W-1:0] sum;

// Wide enough that the sum of all full-scale levels never wraps
always_comb begin
	sum = '0;
	for (int c = 0; c < N; c++)
		sum = sum + `DMC_MIX_W'(level[c]);
end

always_ff @(posedge clk, negedge n_reset) begin
	if (~n_reset)
		mix_out <= '0;
	else
		mix_out <= sum;
end

endmodule

// ==== verilog/dmc_pkg.sv ====
package dmc_pkg;

	typedef struct packed {
		logic irq_en;
		logic loop;
		logic [1:0] spare;
		logic [3:0] rate;
	} dmc_ctrl_t;

	typedef struct packed {
		logic spare;
		logic [6:0] level;
	} dmc_level_t;

	// The same written byte seen by each of the four channel registers
	typedef union packed {
		dmc_ctrl_t ctrl;
		dmc_level_t lvl;
		logic [7:0] raw;
	} dmc_reg_u;

	typedef struct packed {
		logic valid;
		logic [1:0] idx;
		dmc_reg_u data;
	} reg_wr_t;

	typedef struct packed {
		logic req;
		logic [15:0] addr;
	} fetch_req_t;

	typedef struct packed {
		logic rdy;
		logic [7:0] data;
	} fetch_rsp_t;

	typedef struct packed {
		logic req;
		logic [15:0] addr;
	} mem_req_t;

endpackage

// ==== verilog/dmc_rate_rom.sv ====
`include "dmc_defs.svh"

module dmc_rate_rom (
	input logic [3:0] rate,
	output logic [`DMC_TIMER_W-1:0] period
);

// NTSC bit periods, counted in clk cycles
always_comb begin
	case (rate)
		4'd0: period = 9'd428;
		4'd1: period = 9'd380;
		4'd2: period = 9'd340;
		4'd3: period = 9'd320;
		4'd4: period = 9'd286;
		4'd5: period = 9'd254;
		4'd6: period = 9'd226;
		4'd7: period = 9'd214;
		4'd8: period = 9'd190;
		4'd9: period = 9'd160;
		4'd10: period = 9'd142;
		4'd11: period = 9'd128;
		4'd12: period = 9'd106;
		4'd13: period = 9'd84;
		4'd14: period = 9'd72;
		default: period = 9'd54;
	endcase
end

endmodule

// ==== verilog/dmc_reg_decode.sv ====
`include "dmc_defs.svh"

module dmc_reg_decode (
	input logic clk,
	input logic n_reset,
	input logic sys_we,
	input logic [15:0] sys_addr,
	input logic [7:0] sys_wdata,
	output dmc_pkg::reg_wr_t reg_wr [`DMC_NUM_CHANNELS],
	output logic [`DMC_NUM_CHANNELS-1:0] en,
	output logic [`DMC_NUM_CHANNELS-1:0] start,
	output logic irq_clr
);

localparam int N = `DMC_NUM_CHANNELS;

logic [15:0] offset;
logic ctrl_hit;
logic [N-1:0] win_hit;

assign offset = sys_addr - `DMC_BASE_ADDR;

// The control address wins over any channel window that covers it
assign ctrl_hit = sys_we && sys_addr == `DMC_CTRL_ADDR;

always_comb begin
	for (int c = 0; c < N; c++)
		win_hit[c] = sys_we && !ctrl_hit && offset[15:2] == 14'(c);
end

always_ff @(posedge clk, negedge n_reset) begin
	if (~n_reset) begin
		for (int c = 0; c < N; c++)
			reg_wr[c] <= '0;
	end else begin
		for (int c = 0; c < N; c++) begin
			reg_wr[c].valid <= win_hit[c];
			reg_wr[c].idx <= offset[1:0];
			reg_wr[c].data <= sys_wdata;
		end
	end
end

always_ff @(posedge clk, negedge n_reset) begin
	if (~n_reset) begin
		en <= '0;
		start <= '0;
		irq_clr <= 1'b0;
	end else begin
		irq_clr <= ctrl_hit;
		if (ctrl_hit) begin
			en <= sys_wdata[N-1:0];
			start <= sys_wdata[N-1:0]; // Every set bit restarts its channel
		end else begin
			start <= '0;
		end
	end
end

endmodule

// ==== verilog/dmc_top.sv ====
`include "dmc_defs.svh"

module dmc_top (
	input logic clk,
	input logic n_reset,
	input logic sys_we,
	input logic [15:0] sys_addr,
	input logic [7:0] sys_wdata,
	input logic mem_rdy,
	input logic [7:0] mem_data,
	output dmc_pkg::mem_req_t mem_req,
	output logic [`DMC_MIX_W-1:0] mix_out,
	output logic [`DMC_NUM_CHANNELS-1:0] act,
	output logic [`DMC_NUM_CHANNELS-1:0] irq
);

dmc_pkg::reg_wr_t reg_wr [`DMC_NUM_CHANNELS];
dmc_pkg::fetch_req_t fetch_req [`DMC_NUM_CHANNELS];
dmc_pkg::fetch_rsp_t fetch_rsp [`DMC_NUM_CHANNELS];
logic [`DMC_NUM_CHANNELS-1:0] en;
logic [`DMC_NUM_CHANNELS-1:0] start;
logic irq_clr;
logic [6:0] level [`DMC_NUM_CHANNELS];

dmc_reg_decode dec0 (.clk(clk), .n_reset(n_reset), .sys_we(sys_we), .sys_addr(sys_addr),
	.sys_wdata(sys_wdata), .reg_wr(reg_wr), .en(en), .start(start), .irq_clr(irq_clr));

for (genvar g = 0; g < `DMC_NUM_CHANNELS; g++) begin : g_ch
	dmc_channel ch (.clk(clk), .n_reset(n_reset), .reg_wr(reg_wr[g]), .en(en[g]),
		.start(start[g]), .irq_clr(irq_clr), .fetch_req(fetch_req[g]),
		.fetch_rsp(fetch_rsp[g]), .level(level[g]), .act(act[g]), .irq(irq[g]));
end

dmc_fetch_arbiter arb0 (.clk(clk), .n_reset(n_reset), .fetch_req(fetch_req),
	.fetch_rsp(fetch_rsp), .mem_req(mem_req), .mem_rdy(mem_rdy), .mem_data(mem_data));

dmc_mixer mix0 (.clk(clk), .n_reset(n_reset), .level(level), .mix_out(mix_out));

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/dmc_pkg.sv
verilog/dmc_rate_rom.sv
verilog/dmc_reg_decode.sv
verilog/dmc_channel.sv
verilog/dmc_fetch_arbiter.sv
verilog/dmc_mixer.sv
verilog/dmc_top.sv
tb/tb_clock.sv
tb/dmc_mem_model.sv
tb/dmc_tb.sv
